//--- build.f
+incdir+logic
logic/mem_access_pkg.sv
logic/uart_pkg.sv
logic/word_ram.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/mem_io_bridge.sv
logic/mem_io_top.sv
tests/mem_io_tb.sv

//--- logic/bridge_defines.svh
// ################################################
// bridge address map and sizing
// i/o register addresses, ram depth and uart bit period
// ################################################
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// leds in the low nibble, active low
`define ADDR_LED 32'hFFFF_FFFC

// transmit register reads all ones while idle
`define ADDR_UART_OUT 32'hFFFF_FFF8

// receive register reads all ones when empty
`define ADDR_UART_IN 32'hFFFF_FFF4

// word address bits of the on-chip ram
`define RAM_ADDR_BITS 8

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 8

`endif

//--- logic/mem_access_pkg.sv
// ################################################
// mem_access_pkg
// client access types and the data word lane views
// ################################################
package mem_access_pkg;

  // read request type
  // low bits give the size and bit 2 asks for sign extension
  typedef enum logic [2:0] {
    RD_NONE   = 3'b000,
    RD_BYTE   = 3'b001,
    RD_HALF   = 3'b010,
    RD_WORD   = 3'b011,
    RD_BYTE_S = 3'b101,
    RD_HALF_S = 3'b110,
    RD_WORD_S = 3'b111
  } read_type_e;

  // write request type
  typedef enum logic [1:0] {
    WR_NONE = 2'b00,
    WR_BYTE = 2'b01,
    WR_HALF = 2'b10,
    WR_WORD = 2'b11
  } write_type_e;

  // one bus word seen as byte lanes or as half word lanes
  // lane 0 is the least significant
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } bus_word_u;

endpackage

//--- logic/mem_io_bridge.sv
// ################################################
// mem_io_bridge
// client load/store to byte-enabled ram words plus
// led and uart registers at the top of the map
// ################################################
`timescale 1ns/100ps
`include "bridge_defines.svh"

module mem_io_bridge
  import mem_access_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable_i,
  input  read_type_e  read_type_i,
  input  write_type_e write_type_i,
  input  logic [31:0] address_i,
  input  logic [31:0] data_i,
  output logic [31:0] data_o,
  output logic        data_ready_o,
  output logic        busy_o,
  output logic [3:0]  led_o,
  output logic        uart_tx_o,
  input  logic        uart_rx_i
);

  logic is_led, is_tx, is_rx, is_io;
  logic is_rd, is_wr;
  logic [1:0] access_size;
  logic misaligned;

  logic        ram_en;
  logic [3:0]  ram_wr_en;
  logic [31:0] ram_rdata;
  logic        ram_ready;
  logic        ram_busy;
  bus_word_u   wr_word;
  bus_word_u   rd_word;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  logic [31:0] ram_data;

  // i/o registers
  logic [3:0]  led_q;
  logic [31:0] tx_shadow_q;
  logic        tx_go_q;
  // busy from the transmitter is not valid yet
  logic        tx_wait_q;
  logic        tx_restart_q;
  logic        tx_busy;
  logic [31:0] rx_data_q;
  logic        rx_go_q;
  logic [7:0]  rx_byte;
  logic        rx_ready;

  assign is_led = address_i == `ADDR_LED;
  assign is_tx  = address_i == `ADDR_UART_OUT;
  assign is_rx  = address_i == `ADDR_UART_IN;
  assign is_io  = is_led || is_tx || is_rx;
  assign is_rd  = read_type_i != RD_NONE;
  assign is_wr  = write_type_i != WR_NONE;

  // size code is shared by reads and writes
  assign access_size = is_wr ? write_type_i : read_type_i[1:0];
  assign misaligned  = (access_size == 2'b10 && address_i[0]) ||
                       (access_size == 2'b11 && address_i[1:0] != 2'b00);

  // i/o answers at once, ram through its handshake
  assign ram_en       = enable_i && !is_io;
  assign busy_o       = ram_en && ram_busy;
  assign data_ready_o = enable_i && (is_io || ram_ready);
  assign led_o        = led_q;

  // steer write data onto its lanes
  always_comb begin
    wr_word   = '0;
    ram_wr_en = 4'b0000;
    if (!misaligned) begin
      unique case (write_type_i)
        WR_BYTE: begin
          wr_word.bytes[address_i[1:0]] = data_i[7:0];
          ram_wr_en[address_i[1:0]]     = 1'b1;
        end
        WR_HALF: begin
          wr_word.halves[address_i[1]] = data_i[15:0];
          ram_wr_en = address_i[1] ? 4'b1100 : 4'b0011;
        end
        WR_WORD: begin
          wr_word   = data_i;
          ram_wr_en = 4'b1111;
        end
        default: ram_wr_en = 4'b0000;
      endcase
    end
  end

  // pick the lane and extend per read type
  always_comb begin
    rd_word  = ram_rdata;
    sel_byte = rd_word.bytes[address_i[1:0]];
    sel_half = rd_word.halves[address_i[1]];
    ram_data = '0;
    unique case (read_type_i)
      RD_BYTE, RD_BYTE_S: ram_data = {{24{read_type_i[2] & sel_byte[7]}}, sel_byte};
      RD_HALF, RD_HALF_S: begin
        if (!misaligned) begin
          ram_data = {{16{read_type_i[2] & sel_half[15]}}, sel_half};
        end
      end
      RD_WORD, RD_WORD_S: begin
        if (!misaligned) begin
          ram_data = rd_word;
        end
      end
      default: ram_data = '0;
    endcase
  end

  always_comb begin
    data_o = '0;
    if (enable_i && is_rd) begin
      if (is_led) begin
        data_o = {28'h0, led_q};
      end else if (is_tx) begin
        data_o = tx_shadow_q;
      end else if (is_rx) begin
        data_o = rx_data_q;
      end else begin
        data_o = ram_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_q        <= 4'hF;
      tx_shadow_q  <= '1;
      tx_go_q      <= 1'b0;
      tx_wait_q    <= 1'b0;
      tx_restart_q <= 1'b0;
      rx_data_q    <= '1;
      rx_go_q      <= 1'b1;
    end else begin
      tx_wait_q    <= 1'b0;
      tx_restart_q <= 1'b0;

      // a read empties the receive register
      if (enable_i && is_rd && is_rx) begin
        rx_data_q <= '1;
      end else if (rx_go_q && rx_ready) begin
        // older byte is overwritten if never read
        rx_data_q <= {24'h0, rx_byte};
        rx_go_q   <= 1'b0;
      end
      // one cycle of go low acknowledges the receiver
      if (!rx_go_q) begin
        rx_go_q <= 1'b1;
      end

      // frame done so acknowledge and go idle
      if (tx_go_q && !tx_busy && !tx_wait_q) begin
        tx_go_q     <= 1'b0;
        tx_shadow_q <= '1;
      end
      if (tx_restart_q) begin
        tx_go_q   <= 1'b1;
        tx_wait_q <= 1'b1;
      end
      if (enable_i && is_wr && is_tx) begin
        tx_shadow_q <= {24'h0, data_i[7:0]};
        if (tx_go_q) begin
          // cancel the running frame then start over
          tx_go_q      <= 1'b0;
          tx_restart_q <= 1'b1;
        end else begin
          tx_go_q   <= 1'b1;
          tx_wait_q <= 1'b1;
        end
      end

      if (enable_i && is_wr && is_led) begin
        led_q <= data_i[3:0];
      end
    end
  end

  word_ram u_ram (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable_i (ram_en),
    .addr_i   (address_i[`RAM_ADDR_BITS+1:2]),
    .wdata_i  (wr_word),
    .wr_en_i  (ram_wr_en),
    .rdata_o  (ram_rdata),
    .ready_o  (ram_ready),
    .busy_o   (ram_busy)
  );

  uart_tx u_uart_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .go_i   (tx_go_q),
    .data_i (tx_shadow_q[7:0]),
    .tx_o   (uart_tx_o),
    .busy_o (tx_busy)
  );

  uart_rx u_uart_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_i         (uart_rx_i),
    .go_i         (rx_go_q),
    .data_o       (rx_byte),
    .data_ready_o (rx_ready)
  );

  a_no_rd_and_wr : assert property (@(posedge clk) disable iff (!rst_n)
    enable_i |-> !(is_rd && is_wr))
    else $error("read and write requested together");

endmodule

//--- logic/mem_io_top.sv
// ################################################
// mem_io_top
// board level wrapper around the load/store bridge
// ################################################
`timescale 1ns/100ps

module mem_io_top
  import mem_access_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable_i,
  input  read_type_e  read_type_i,
  input  write_type_e write_type_i,
  input  logic [31:0] address_i,
  input  logic [31:0] data_i,
  output logic [31:0] data_o,
  output logic        data_ready_o,
  output logic        busy_o,
  // active low leds
  output logic [3:0]  led_o,
  output logic        uart_tx_o,
  input  logic        uart_rx_i
);

  mem_io_bridge u_bridge (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .read_type_i  (read_type_i),
    .write_type_i (write_type_i),
    .address_i    (address_i),
    .data_i       (data_i),
    .data_o       (data_o),
    .data_ready_o (data_ready_o),
    .busy_o       (busy_o),
    .led_o        (led_o),
    .uart_tx_o    (uart_tx_o),
    .uart_rx_i    (uart_rx_i)
  );

endmodule

//--- logic/uart_pkg.sv
// ################################################
// uart_pkg
// frame states shared by the serial tx and rx
// ################################################
package uart_pkg;

  // 8N1 frame position
  typedef enum logic [1:0] {
    // line idle, waiting for work
    UART_IDLE  = 2'd0,
    // start bit
    UART_START = 2'd1,
    // eight data bits lsb first
    UART_DATA  = 2'd2,
    // stop bit
    UART_STOP  = 2'd3
  } uart_state_e;

endpackage

//--- logic/uart_rx.sv
// ################################################
// uart_rx
// 8N1 serial receiver, mid-bit sampling, go/ready handshake
// ################################################
`timescale 1ns/100ps
`include "bridge_defines.svh"

module uart_rx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_i,
  input  logic       go_i,
  output logic [7:0] data_o,
  output logic       data_ready_o
);

  localparam int CLKS  = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS - 1);
  // start bit is checked half a bit after the falling edge
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS / 2 - 1);

  uart_state_e      state_q;
  logic [1:0]       sync_q;
  logic             rx_prev_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic [7:0]       data_q;
  logic             ready_q;
  logic             rx_s;

  // synchronized line
  assign rx_s         = sync_q[1];
  assign data_o       = data_q;
  assign data_ready_o = ready_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
      state_q   <= UART_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      ready_q   <= 1'b0;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;

      // go low is the acknowledge
      if (!go_i) begin
        ready_q <= 1'b0;
      end

      unique case (state_q)
        UART_IDLE: begin
          if (rx_prev_q && !rx_s) begin
            cnt_q   <= '0;
            state_q <= UART_START;
          end
        end
        UART_START: begin
          if (cnt_q == CNT_HALF) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // glitch, not a start bit
            state_q   <= rx_s ? UART_IDLE : UART_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (cnt_q == CNT_LAST) begin
            // centre of a data bit, lsb arrives first
            cnt_q     <= '0;
            shift_q   <= {rx_s, shift_q[7:1]};
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= UART_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          if (cnt_q == CNT_LAST) begin
            state_q <= UART_IDLE;
            // framing error drops the byte
            if (rx_s) begin
              data_q  <= shift_q;
              ready_q <= 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/uart_tx.sv
// ################################################
// uart_tx
// 8N1 serial transmitter with go/busy handshake
// ################################################
`timescale 1ns/100ps
`include "bridge_defines.svh"

module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go_i,
  input  logic [7:0] data_i,
  output logic       tx_o,
  output logic       busy_o
);

  localparam int CLKS  = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS - 1);

  uart_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic [7:0]       shift_q;
  logic             tx_q;
  logic             busy_q;
  // set once go has been low, so one go sends one byte
  logic             armed_q;
  logic             bit_end;

  assign bit_end = cnt_q == CNT_LAST;
  assign tx_o    = tx_q;
  assign busy_o  = busy_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= UART_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      tx_q      <= 1'b1;
      busy_q    <= 1'b0;
      armed_q   <= 1'b1;
    end else if (!go_i) begin
      // go low acknowledges the frame or cancels it
      state_q <= UART_IDLE;
      tx_q    <= 1'b1;
      busy_q  <= 1'b0;
      armed_q <= 1'b1;
    end else begin
      unique case (state_q)
        UART_IDLE: begin
          if (armed_q) begin
            // latch the byte and drive the start bit
            shift_q <= data_i;
            tx_q    <= 1'b0;
            busy_q  <= 1'b1;
            armed_q <= 1'b0;
            cnt_q   <= '0;
            state_q <= UART_START;
          end
        end
        UART_START: begin
          if (bit_end) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_q      <= shift_q[0];
            state_q   <= UART_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              tx_q    <= 1'b1;
              state_q <= UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
              shift_q   <= shift_q >> 1;
              tx_q      <= shift_q[1];
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          // busy drops after a full stop bit
          if (bit_end) begin
            busy_q  <= 1'b0;
            state_q <= UART_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  a_idle_line_high : assert property (@(posedge clk) disable iff (!rst_n)
    state_q == UART_IDLE |-> tx_o)
    else $error("uart_tx line low while idle");

endmodule

//--- logic/word_ram.sv
// ################################################
// word_ram
// byte-enabled 32-bit word ram, one cycle read latency
// ################################################
`timescale 1ns/100ps
`include "bridge_defines.svh"

module word_ram (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable_i,
  input  logic [`RAM_ADDR_BITS-1:0] addr_i,
  input  logic [31:0]               wdata_i,
  input  logic [3:0]                wr_en_i,
  output logic [31:0]               rdata_o,
  output logic                      ready_o,
  output logic                      busy_o
);

  logic [31:0] mem [2**`RAM_ADDR_BITS];
  logic [31:0] rdata_q;

  // request seen in the previous cycle
  logic                      served_q;
  logic [`RAM_ADDR_BITS-1:0] last_addr_q;
  logic [3:0]                last_wr_en_q;
  logic [31:0]               last_wdata_q;

  logic same_req;

  // the held request was already served at the last edge
  assign same_req = served_q && addr_i == last_addr_q &&
                    wr_en_i == last_wr_en_q && wdata_i == last_wdata_q;

  // new request costs one busy cycle then stays ready while held
  assign busy_o  = enable_i && !same_req;
  assign ready_o = enable_i && same_req;
  assign rdata_o = rdata_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      served_q <= 1'b0;
    end else begin
      served_q <= enable_i;
    end
  end

  // remember what was served
  always_ff @(posedge clk) begin
    if (enable_i) begin
      last_addr_q  <= addr_i;
      last_wr_en_q <= wr_en_i;
      last_wdata_q <= wdata_i;
    end
  end

  // byte lane writes, read returns the word before the write
  always_ff @(posedge clk) begin
    if (busy_o) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_en_i[i]) begin
          mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
      rdata_q <= mem[addr_i];
    end
  end

  // a held read returns the word stored at its address
  a_read_data : assert property (@(posedge clk) disable iff (!rst_n)
    ready_o && wr_en_i == 4'b0000 |-> rdata_o === mem[addr_i])
    else $error("word_ram read data differs from the stored word");

endmodule

//--- run.sh
#!/bin/sh
# compile and run the bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module mem_io_tb -o mem_io_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/mem_io_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "no summary line found in $LOG"
  exit 1
fi
exit 0

//--- tests/mem_io_tb.sv
// ################################################
// mem_io_tb
// testbench for the load/store bridge, ram lanes,
// leds and both uart directions
// ################################################
`timescale 1ns/100ps
`include "bridge_defines.svh"

module mem_io_tb
  import mem_access_pkg::*;
();

  localparam int CLKS           = `UART_CLKS_PER_BIT;
  localparam int FRAME_CYCLES   = 10 * CLKS;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_RANDOM     = 8;
  localparam int RAM_ACCESSES   = 2 * NUM_RANDOM + 14;
  localparam int IO_ACCESSES    = 12;
  // busy, ready and idle cycle of one access
  localparam int ACCESS_CYCLES  = 3;
  localparam int ACCESS_TIMEOUT = 16;
  localparam int POLL_LIMIT     = 2 * CLKS;
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + FRAME_CYCLES * 2 +
    (RAM_ACCESSES + IO_ACCESSES + 2 * POLL_LIMIT) * ACCESS_CYCLES);
  localparam logic [7:0] RX_BYTE = 8'hC3;

  logic        clk;
  logic        rst_n;
  logic        enable_i;
  read_type_e  read_type_i;
  write_type_e write_type_i;
  logic [31:0] address_i;
  logic [31:0] data_i;
  logic [31:0] data_o;
  logic        data_ready_o;
  logic        busy_o;
  logic [3:0]  led_o;
  logic        uart_tx_o;
  logic        uart_rx_i;
  logic        io_addr;

  int          errors;
  int          test_num;
  int          failed_tests;
  int          errors_at_start;
  string       test_name;

  // scoreboard of the random ram words
  logic [`RAM_ADDR_BITS-1:0] sb_idx [NUM_RANDOM];
  logic [31:0]               ram_model [2**`RAM_ADDR_BITS];
  logic [7:0]                tx_seen;

  mem_io_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .read_type_i  (read_type_i),
    .write_type_i (write_type_i),
    .address_i    (address_i),
    .data_i       (data_i),
    .data_o       (data_o),
    .data_ready_o (data_ready_o),
    .busy_o       (busy_o),
    .led_o        (led_o),
    .uart_tx_o    (uart_tx_o),
    .uart_rx_i    (uart_rx_i)
  );

  function automatic logic is_io_address(input logic [31:0] addr);
    return addr == `ADDR_LED || addr == `ADDR_UART_OUT || addr == `ADDR_UART_IN;
  endfunction

  assign io_addr = is_io_address(address_i);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // i/o answers in the same cycle and never looks busy
  io_same_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    enable_i && io_addr |-> data_ready_o && !busy_o)
    else begin
      $display("[FAIL] data_ready_o/busy_o 0x%h/0x%h on i/o access", data_ready_o, busy_o);
      errors++;
    end

  // first ram cycle is busy
  ram_first_busy : assert property (@(posedge clk) disable iff (!rst_n)
    enable_i && !io_addr && !$past(enable_i) |-> busy_o && !data_ready_o)
    else begin
      $display("[FAIL] busy_o/data_ready_o 0x%h/0x%h in first ram cycle", busy_o, data_ready_o);
      errors++;
    end

  // request held one more cycle is answered
  ram_next_ready : assert property (@(posedge clk) disable iff (!rst_n)
    enable_i && !io_addr && $past(enable_i) |-> data_ready_o && !busy_o)
    else begin
      $display("[FAIL] data_ready_o/busy_o 0x%h/0x%h one cycle after ram request",
               data_ready_o, busy_o);
      errors++;
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // one client access, inputs held until data_ready_o, then one idle cycle
  task automatic bus_access(input write_type_e wt, input read_type_e rt,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int   waited;
    logic first_busy;
    logic done;
    waited = 0;
    done   = 1'b0;
    rdata  = '0;
    @(negedge clk);
    enable_i     = 1'b1;
    write_type_i = wt;
    read_type_i  = rt;
    address_i    = addr;
    data_i       = wdata;
    #1;
    first_busy = busy_o;
    while (!done && waited <= ACCESS_TIMEOUT) begin
      if (data_ready_o) begin
        rdata = data_o;
        done  = 1'b1;
      end else begin
        @(negedge clk);
        #1;
        waited++;
      end
    end
    if (!done) begin
      $display("no data_ready_o within %0d cycles at address 0x%08h", ACCESS_TIMEOUT, addr);
      errors++;
    end else if (is_io_address(addr)) begin
      check_value("data_ready_o wait cycles on i/o", waited, 0);
      check_value("busy_o on i/o", first_busy, 1'b0);
    end else begin
      check_value("data_ready_o wait cycles on ram", waited, 1);
      check_value("busy_o in first ram cycle", first_busy, 1'b1);
    end
    @(negedge clk);
    enable_i     = 1'b0;
    write_type_i = WR_NONE;
    read_type_i  = RD_NONE;
    address_i    = '0;
    data_i       = '0;
  endtask

  task automatic do_write(input write_type_e wt, input logic [31:0] addr,
                          input logic [31:0] wdata);
    logic [31:0] ignored;
    bus_access(wt, RD_NONE, addr, wdata, ignored);
  endtask

  task automatic do_read(input read_type_e rt, input logic [31:0] addr,
                         output logic [31:0] rdata);
    bus_access(WR_NONE, rt, addr, 32'h0, rdata);
  endtask

  task automatic read_expect(input string name, input read_type_e rt,
                             input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    do_read(rt, addr, rd);
    check_value(name, rd, exp);
  endtask

  // serial monitor, samples uart_tx_o at bit centres
  task automatic capture_tx_frame(output logic [7:0] value);
    int waited;
    waited = 0;
    value  = '0;
    @(negedge clk);
    while (uart_tx_o && waited < 4 * CLKS) begin
      @(negedge clk);
      waited++;
    end
    if (uart_tx_o) begin
      $display("no start bit on uart_tx_o after the write");
      errors++;
    end else begin
      repeat (CLKS / 2) @(negedge clk);
      check_value("uart_tx_o start bit", uart_tx_o, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS) @(negedge clk);
        value[i] = uart_tx_o;
      end
      repeat (CLKS) @(negedge clk);
      check_value("uart_tx_o stop bit", uart_tx_o, 1'b1);
    end
  endtask

  // serial driver, lsb first with one stop bit
  task automatic send_rx_frame(input logic [7:0] value);
    @(negedge clk);
    uart_rx_i = 1'b0;
    repeat (CLKS) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = value[i];
      repeat (CLKS) @(negedge clk);
    end
    uart_rx_i = 1'b1;
    repeat (CLKS) @(negedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    test_num++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", test_num, test_name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_num, test_name, errors - errors_at_start);
    end
  endtask

  task automatic test_ram_words();
    logic [31:0] rd;
    logic [31:0] addr;
    begin_test("ram random words");
    for (int i = 0; i < NUM_RANDOM; i++) begin
      sb_idx[i] = `RAM_ADDR_BITS'($urandom());
      ram_model[sb_idx[i]] = $urandom();
      addr = {{(30 - `RAM_ADDR_BITS){1'b0}}, sb_idx[i], 2'b00};
      do_write(WR_WORD, addr, ram_model[sb_idx[i]]);
    end
    // a repeated index keeps its last value in the model
    for (int i = 0; i < NUM_RANDOM; i++) begin
      addr = {{(30 - `RAM_ADDR_BITS){1'b0}}, sb_idx[i], 2'b00};
      do_read(RD_WORD, addr, rd);
      check_value("data_o ram word", rd, ram_model[sb_idx[i]]);
    end
    end_test();
  endtask

  task automatic test_ram_lanes();
    begin_test("ram byte and half lanes");
    do_write(WR_WORD, 32'h40, 32'h1122_3344);
    // upper data bits must not reach the ram
    do_write(WR_BYTE, 32'h41, 32'hDEAD_BEF0);
    do_write(WR_HALF, 32'h42, 32'h5555_8765);
    // misaligned half writes nothing
    do_write(WR_HALF, 32'h43, 32'h0000_FFFF);
    read_expect("data_o word", RD_WORD, 32'h40, 32'h8765_F044);
    read_expect("data_o byte 1", RD_BYTE, 32'h41, 32'h0000_00F0);
    read_expect("data_o signed byte 1", RD_BYTE_S, 32'h41, 32'hFFFF_FFF0);
    read_expect("data_o signed byte 0", RD_BYTE_S, 32'h40, 32'h0000_0044);
    read_expect("data_o byte 3", RD_BYTE, 32'h43, 32'h0000_0087);
    read_expect("data_o half 1", RD_HALF, 32'h42, 32'h0000_8765);
    read_expect("data_o signed half 1", RD_HALF_S, 32'h42, 32'hFFFF_8765);
    read_expect("data_o signed half 0", RD_HALF_S, 32'h40, 32'hFFFF_F044);
    read_expect("data_o misaligned word", RD_WORD_S, 32'h41, 32'h0000_0000);
    end_test();
  endtask

  task automatic test_leds();
    begin_test("led register");
    check_value("led_o after reset", led_o, 4'hF);
    do_write(WR_WORD, `ADDR_LED, 32'h0000_005A);
    check_value("led_o", led_o, 4'hA);
    read_expect("data_o led", RD_WORD, `ADDR_LED, 32'h0000_000A);
    do_write(WR_WORD, `ADDR_LED, 32'h0000_0003);
    check_value("led_o", led_o, 4'h3);
    read_expect("data_o led", RD_WORD, `ADDR_LED, 32'h0000_0003);
    end_test();
  endtask

  task automatic test_uart_out();
    logic [31:0] rd;
    logic [7:0]  tx_byte;
    int          polls;
    begin_test("uart transmit");
    tx_byte = 8'($urandom());
    polls   = 0;
    check_value("uart_tx_o idle", uart_tx_o, 1'b1);
    read_expect("data_o uart_out idle", RD_WORD, `ADDR_UART_OUT, 32'hFFFF_FFFF);
    fork
      capture_tx_frame(tx_seen);
      begin
        do_write(WR_WORD, `ADDR_UART_OUT, {24'h123456, tx_byte});
        read_expect("data_o uart_out sending", RD_WORD, `ADDR_UART_OUT, {24'h0, tx_byte});
      end
    join
    check_value("uart_tx_o byte", tx_seen, tx_byte);
    // shadow falls back to all ones once busy drops
    do_read(RD_WORD, `ADDR_UART_OUT, rd);
    while (rd !== 32'hFFFF_FFFF && polls < POLL_LIMIT) begin
      check_value("data_o uart_out stop", rd, {24'h0, tx_byte});
      do_read(RD_WORD, `ADDR_UART_OUT, rd);
      polls++;
    end
    check_value("data_o uart_out after frame", rd, 32'hFFFF_FFFF);
    end_test();
  endtask

  task automatic test_uart_in();
    logic [31:0] rd;
    int          polls;
    begin_test("uart receive");
    polls = 0;
    send_rx_frame(RX_BYTE);
    do_read(RD_WORD, `ADDR_UART_IN, rd);
    while (rd === 32'hFFFF_FFFF && polls < POLL_LIMIT) begin
      do_read(RD_WORD, `ADDR_UART_IN, rd);
      polls++;
    end
    check_value("data_o uart_in", rd, {24'h0, RX_BYTE});
    // the read emptied the register
    read_expect("data_o uart_in empty", RD_WORD, `ADDR_UART_IN, 32'hFFFF_FFFF);
    end_test();
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    errors       = 0;
    test_num     = 0;
    failed_tests = 0;
    rst_n        = 1'b0;
    enable_i     = 1'b0;
    read_type_i  = RD_NONE;
    write_type_i = WR_NONE;
    address_i    = '0;
    data_i       = '0;
    uart_rx_i    = 1'b1;
    void'($urandom(45));
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    test_ram_words();
    test_ram_lanes();
    test_leds();
    test_uart_out();
    test_uart_in();

    $display("tests run %0d, tests failed %0d, check errors %0d",
             test_num, failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
